// ==== ioPkg.sv ====
package ioPkg;

	////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////

	// Page/offset view of a CPU address
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} pageOffT;

	// One address word, two decodings
	typedef union packed {
		logic [15:0] raw;   // Full address, vector match
		pageOffT fields;    // Register decode
	} busAddrT;

	typedef struct packed {
		logic write;        // High for CPU write
		busAddrT addr;
		logic [7:0] data;   // Write data, ignored on reads
	} busReqT;

	typedef struct packed {
		logic [7:0] data;
		busAddrT addr;      // Address this byte answers
	} busRespT;

	// Register file seen by the math unit
	typedef struct packed {
		logic [7:0] led;
		logic [15:0] facA;
		logic [15:0] facB;
		logic [1:0] gfxMode;  // Bit 1 set selects graphics pitch
		logic [7:0] screenX;
		logic [7:0] screenY;
	} ioRegsT;

	////////////////////////////////////////////////////////////
	// Request queue
	////////////////////////////////////////////////////////////
	localparam int FIFO_DEPTH = 4;  // Also the host's credits after reset
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	////////////////////////////////////////////////////////////
	// Register map, top page of the CPU space
	////////////////////////////////////////////////////////////
	localparam logic [7:0] IO_PAGE = 8'hFD;

	localparam logic [15:0] ADDR_LED = 16'd65000;
	localparam logic [15:0] ADDR_FAC_A_LO = 16'd65010;
	localparam logic [15:0] ADDR_FAC_A_HI = 16'd65011;
	localparam logic [15:0] ADDR_FAC_B_LO = 16'd65012;
	localparam logic [15:0] ADDR_FAC_B_HI = 16'd65013;
	localparam logic [15:0] ADDR_PROD_0 = 16'd65014;  // Product LSB
	localparam logic [15:0] ADDR_PROD_1 = 16'd65015;
	localparam logic [15:0] ADDR_PROD_2 = 16'd65016;
	localparam logic [15:0] ADDR_PROD_3 = 16'd65017;  // Product MSB
	localparam logic [15:0] ADDR_GFX_MODE = 16'd65018;
	localparam logic [15:0] ADDR_RANDOM = 16'd65019;
	localparam logic [15:0] ADDR_SCREEN_X = 16'd65020;
	localparam logic [15:0] ADDR_SCREEN_Y = 16'd65021;
	localparam logic [15:0] ADDR_SCREEN_LO = 16'd65022;
	localparam logic [15:0] ADDR_SCREEN_HI = 16'd65023;

	// Vector locations, low byte at the even address
	localparam logic [15:0] ADDR_NMI_A = 16'hFFEA;
	localparam logic [15:0] ADDR_NMI_B = 16'hFFFA;
	localparam logic [15:0] ADDR_IRQ_A = 16'hFFEE;
	localparam logic [15:0] ADDR_IRQ_B = 16'hFFFE;
	localparam logic [15:0] ADDR_RESET_VEC = 16'hFFFC;

	localparam logic [15:0] VEC_NMI = 16'h0D5D;
	localparam logic [15:0] VEC_IRQ = 16'h0D39;
	localparam logic [15:0] VEC_RESET = 16'h0200;

	////////////////////////////////////////////////////////////
	// Coprocessor and timer constants
	////////////////////////////////////////////////////////////
	localparam logic [15:0] SCREEN_BASE = 16'h9600;  // Graphics memory base
	localparam logic [7:0] TEXT_PITCH = 8'd80;
	localparam logic [7:0] GFX_PITCH = 8'd160;

	localparam int MUL_STEPS = 16;
	localparam int MUL_CNT_W = $clog2(MUL_STEPS);

	localparam int JIFFY_INTERVAL = 500000;  // 10 ms at 50 MHz
	localparam int JIFFY_W = $clog2(JIFFY_INTERVAL + 1);
	localparam int IRQ_LENGTH = 50;
	localparam int IRQ_W = $clog2(IRQ_LENGTH + 1);

	localparam logic [7:0] LFSR_SEED = 8'h01;  // Any nonzero value

endpackage

// ==== requestFifo.sv ====
`timescale 1ns/1ps

module requestFifo (
	input logic clk,
	input logic reset,
	input logic push,
	input ioPkg::busReqT pushData,
	input logic pop,
	output logic notEmpty,
	output ioPkg::busReqT headData
);
	import ioPkg::*;

	busReqT mem [FIFO_DEPTH];          // Payload only, no reset
	logic [FIFO_PTR_W-1:0] wrPtr;
	logic [FIFO_PTR_W-1:0] rdPtr;
	logic [FIFO_PTR_W:0] count;        // One extra bit for full

	assign notEmpty = (count != '0);
	assign headData = mem[rdPtr];      // Head visible the cycle after push

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// ==== busSequencer.sv ====
`timescale 1ns/1ps

module busSequencer (
	input logic clk,
	input logic reset,
	input logic notEmpty,
	input ioPkg::busReqT headData,
	input logic [7:0] readData,
	input logic busy,
	output logic pop,
	output logic creditReturn,
	output logic regWrite,
	output logic regRead,
	output ioPkg::busAddrT regAddr,
	output logic [7:0] regData,
	output logic respValid,
	output ioPkg::busRespT resp
);
	import ioPkg::*;

	typedef enum logic [1:0] {
		sIdle,
		sFetch,
		sWaitMath,
		sRespond
	} seqStateT;

	seqStateT state;
	busAddrT curAddr;   // Address of the read in flight
	logic isMath;

	// Head is consumed straight from idle
	assign pop = (state == sIdle) && notEmpty;
	assign creditReturn = pop;            // One credit back per pop
	assign regWrite = pop && headData.write;
	assign regRead = (state == sRespond);  // Also steps the LFSR
	assign regAddr = (state == sIdle) ? headData.addr : curAddr;
	assign regData = headData.data;

	// Bytes that depend on the math unit
	assign isMath = curAddr.raw inside {ADDR_PROD_0, ADDR_PROD_1, ADDR_PROD_2,
		ADDR_PROD_3, ADDR_SCREEN_LO, ADDR_SCREEN_HI};

	always_ff @(posedge clk)
	begin
		if (pop)
			curAddr <= headData.addr;
		if (state == sRespond)
			resp <= '{data: readData, addr: curAddr};
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= sIdle;
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= 1'b0;
			case (state)
				sIdle:
					if (pop && !headData.write)
						state <= sFetch;  // Writes finish in the pop cycle
				sFetch:
					if (isMath && busy)
						state <= sWaitMath;   // Multiply still running
					else
						state <= sRespond;
				sWaitMath:
					if (!busy)
						state <= sRespond;
				sRespond:
				begin
					respValid <= 1'b1;
					state <= sIdle;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

// ==== jiffyTimer.sv ====
`timescale 1ns/1ps

module jiffyTimer (
	input logic clk,
	input logic reset,
	output logic jiffyIrq
);
	import ioPkg::*;

	logic [JIFFY_W-1:0] intervalCnt;  // 0 .. JIFFY_INTERVAL
	logic [IRQ_W-1:0] pulseCnt;       // Cycles of pulse left
	logic wrap;

	assign wrap = (intervalCnt == JIFFY_W'(JIFFY_INTERVAL));
	assign jiffyIrq = (pulseCnt != '0);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			intervalCnt <= '0;
			pulseCnt <= '0;
		end
		else
		begin
			if (wrap)
				intervalCnt <= '0;
			else
				intervalCnt <= intervalCnt + 1'b1;

			// Pulse starts the cycle after the wrap
			if (wrap)
				pulseCnt <= IRQ_W'(IRQ_LENGTH);
			else if (pulseCnt != '0)
				pulseCnt <= pulseCnt - 1'b1;
		end
	end

endmodule

// ==== mathUnit.sv ====
`timescale 1ns/1ps

module mathUnit (
	input logic clk,
	input logic reset,
	input ioPkg::ioRegsT regs,
	input logic start,
	output logic busy,
	output logic [31:0] product,
	output logic [15:0] screenAddr
);
	import ioPkg::*;

	logic [MUL_CNT_W-1:0] stepCount;  // Current multiplier bit
	logic [31:0] acc;                 // Running partial sum
	logic [31:0] partial;
	logic lastStep;
	logic [7:0] pitch;
	logic [15:0] rowOffset;

	////////////////////////////////////////////////////////////
	// Shift-add multiplier, one bit of B per cycle
	////////////////////////////////////////////////////////////
	// Factors sit still in regs while busy, a new write restarts
	assign partial = regs.facB[stepCount] ? ({16'd0, regs.facA} << stepCount) : 32'd0;
	assign lastStep = (stepCount == MUL_CNT_W'(MUL_STEPS - 1));

	always_ff @(posedge clk)
	begin
		if (start)
			acc <= '0;
		else if (busy)
			acc <= acc + partial;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			stepCount <= '0;
			product <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			stepCount <= '0;
		end
		else if (busy)
		begin
			stepCount <= stepCount + 1'b1;
			if (lastStep)
			begin
				busy <= 1'b0;
				product <= acc + partial;  // Old product held until here
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Screen X/Y to video memory address
	////////////////////////////////////////////////////////////
	assign pitch = regs.gfxMode[1] ? GFX_PITCH : TEXT_PITCH;
	assign rowOffset = {8'd0, regs.screenY} * {8'd0, pitch};

	always_ff @(posedge clk)
	begin
		screenAddr <= SCREEN_BASE + {8'd0, regs.screenX} + rowOffset;  // One cycle after write
	end

endmodule

// ==== ioRegisters.sv ====
`timescale 1ns/1ps

module ioRegisters (
	input logic clk,
	input logic reset,
	input logic regWrite,
	input logic regRead,
	input ioPkg::busAddrT regAddr,
	input logic [7:0] regData,
	input logic [31:0] product,
	input logic [15:0] screenAddr,
	output logic [7:0] readData,
	output ioPkg::ioRegsT regs,
	output logic mathStart,
	output logic [7:0] led
);
	import ioPkg::*;

	logic ioHit;          // Address in the register page
	logic [7:0] lfsr;

	assign ioHit = (regAddr.fields.page == IO_PAGE);
	assign led = regs.led;

	// Any factor byte kicks off a new multiply
	assign mathStart = regWrite && ioHit && (regAddr.fields.offset inside {
		ADDR_FAC_A_LO[7:0], ADDR_FAC_A_HI[7:0], ADDR_FAC_B_LO[7:0], ADDR_FAC_B_HI[7:0]});

	////////////////////////////////////////////////////////////
	// CPU write
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			regs <= '0;    // LEDs off
		else if (regWrite && ioHit)
		begin
			case (regAddr.fields.offset)
				ADDR_LED[7:0]: regs.led <= regData;
				ADDR_FAC_A_LO[7:0]: regs.facA[7:0] <= regData;
				ADDR_FAC_A_HI[7:0]: regs.facA[15:8] <= regData;
				ADDR_FAC_B_LO[7:0]: regs.facB[7:0] <= regData;
				ADDR_FAC_B_HI[7:0]: regs.facB[15:8] <= regData;
				ADDR_GFX_MODE[7:0]: regs.gfxMode <= regData[1:0];
				ADDR_SCREEN_X[7:0]: regs.screenX <= regData;
				ADDR_SCREEN_Y[7:0]: regs.screenY <= regData;
				default: ;     // Read-only or unmapped
			endcase
		end
	end

	// Maximal length 8-bit LFSR, advances once per read of the random byte
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			lfsr <= LFSR_SEED;
		else if (regRead && (regAddr.raw == ADDR_RANDOM))
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	////////////////////////////////////////////////////////////
	// CPU read
	////////////////////////////////////////////////////////////
	always_comb
	begin
		readData = 8'h00;  // Unmapped reads as zero
		if (ioHit)
		begin
			case (regAddr.fields.offset)
				ADDR_PROD_0[7:0]: readData = product[7:0];
				ADDR_PROD_1[7:0]: readData = product[15:8];
				ADDR_PROD_2[7:0]: readData = product[23:16];
				ADDR_PROD_3[7:0]: readData = product[31:24];
				ADDR_RANDOM[7:0]: readData = lfsr;           // Value before the step
				ADDR_SCREEN_LO[7:0]: readData = screenAddr[7:0];
				ADDR_SCREEN_HI[7:0]: readData = screenAddr[15:8];
				default: readData = 8'h00;
			endcase
		end
		else
		begin
			// Vector table on the full address
			case (regAddr.raw)
				ADDR_NMI_A, ADDR_NMI_B: readData = VEC_NMI[7:0];
				ADDR_NMI_A + 16'd1, ADDR_NMI_B + 16'd1: readData = VEC_NMI[15:8];
				ADDR_IRQ_A, ADDR_IRQ_B: readData = VEC_IRQ[7:0];
				ADDR_IRQ_A + 16'd1, ADDR_IRQ_B + 16'd1: readData = VEC_IRQ[15:8];
				ADDR_RESET_VEC: readData = VEC_RESET[7:0];
				ADDR_RESET_VEC + 16'd1: readData = VEC_RESET[15:8];
				default: readData = 8'h00;
			endcase
		end
	end

endmodule

// ==== ioController.sv ====
`timescale 1ns/1ps

module ioController (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input ioPkg::busReqT req,
	output logic creditReturn,
	output logic respValid,
	output ioPkg::busRespT resp,
	output logic [7:0] led,
	output logic jiffyIrq
);
	import ioPkg::*;

	////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////
	logic notEmpty;
	busReqT headData;
	logic pop;
	logic regWrite;
	logic regRead;
	busAddrT regAddr;
	logic [7:0] regData;
	logic [7:0] readData;
	ioRegsT regs;
	logic mathStart;
	logic busy;         // Multiply in progress
	logic [31:0] product;
	logic [15:0] screenAddr;

	// Credits guarantee room, so every valid cycle is a push
	requestFifo reqQueue (
		.clk(clk),
		.reset(reset),
		.push(reqValid),
		.pushData(req),
		.pop(pop),
		.notEmpty(notEmpty),
		.headData(headData)
	);

	busSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.notEmpty(notEmpty),
		.headData(headData),
		.readData(readData),
		.busy(busy),
		.pop(pop),
		.creditReturn(creditReturn),
		.regWrite(regWrite),
		.regRead(regRead),
		.regAddr(regAddr),
		.regData(regData),
		.respValid(respValid),
		.resp(resp)
	);

	ioRegisters registers (
		.clk(clk),
		.reset(reset),
		.regWrite(regWrite),
		.regRead(regRead),
		.regAddr(regAddr),
		.regData(regData),
		.product(product),
		.screenAddr(screenAddr),
		.readData(readData),
		.regs(regs),
		.mathStart(mathStart),
		.led(led)
	);

	mathUnit coprocessor (
		.clk(clk),
		.reset(reset),
		.regs(regs),
		.start(mathStart),
		.busy(busy),
		.product(product),
		.screenAddr(screenAddr)
	);

	jiffyTimer jiffy (
		.clk(clk),
		.reset(reset),
		.jiffyIrq(jiffyIrq)
	);

endmodule

// ==== ioChecker.sv ====
`timescale 1ns/1ps

module ioChecker (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic creditReturn,
	input logic respValid,
	input ioPkg::busRespT resp,
	input logic jiffyIrq,
	input logic expValid,
	input ioPkg::busRespT expResp,
	input logic [2:0] expTest,
	input logic endCheck,
	output int errorCount,
	output int pending,
	output int jiffyRises
);
	import ioPkg::*;

	typedef struct packed {
		logic [2:0] test;
		busRespT resp;
	} expEntryT;

	expEntryT expQ [$];      // Reads in request order
	expEntryT entry;
	expEntryT head;
	int sentCount;
	int returnCount;
	int cycleNum;            // Rising edges since reset release
	int lastRise;
	int highCycles;
	logic irqSeen;           // jiffyIrq at the previous falling edge

	function automatic string testName(input logic [2:0] id);
		string name;
		case (id)
			3'd0: name = "vector";
			3'd1: name = "multiply";
			3'd2: name = "screen";
			3'd3: name = "random";
			default: name = "burst";
		endcase
		return name;
	endfunction

	initial
		errorCount = 0;

	////////////////////////////////////////////////////////////
	// Responses and credits
	////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (reset)
		begin
			expQ.delete();
			sentCount = 0;
			returnCount = 0;
		end
		else
		begin
			if (expValid)
			begin
				entry.test = expTest;
				entry.resp = expResp;
				expQ.push_back(entry);
			end
			if (reqValid)
				sentCount++;
			if (creditReturn)
				returnCount++;
			if (returnCount > sentCount)
			begin
				errorCount++;
				$display("Credit returned with no request outstanding");
			end
			if (respValid)
			begin
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("Response for address %h arrived with no read outstanding",
						resp.addr.raw);
				end
				else
				begin
					head = expQ.pop_front();
					if (resp.addr.raw !== head.resp.addr.raw)   // Out of order
					begin
						errorCount++;
						$display("** Error %s address: expected %h, actual %h",
							testName(head.test), head.resp.addr.raw, resp.addr.raw);
					end
					if (resp.data !== head.resp.data)
					begin
						errorCount++;
						$display("** Error %s at %h: expected %h, actual %h",
							testName(head.test), head.resp.addr.raw, head.resp.data, resp.data);
					end
				end
			end
			if (endCheck)
			begin
				if (returnCount != sentCount)
				begin
					errorCount++;
					$display("** Error credits: expected %0d, actual %0d",
						sentCount, returnCount);
				end
				if (expQ.size() != 0)
				begin
					errorCount++;
					$display("%0d reads never got a response", expQ.size());
				end
			end
		end
		pending = expQ.size();
	end

	////////////////////////////////////////////////////////////
	// Jiffy period and pulse width
	////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (reset)
			cycleNum <= 0;
		else
			cycleNum <= cycleNum + 1;
	end

	// Sampled mid-cycle, well away from the edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			irqSeen = 1'b0;
			jiffyRises = 0;
			lastRise = 0;        // First period counts from reset release
			highCycles = 0;
		end
		else
		begin
			if (jiffyIrq && !irqSeen)
			begin
				if (cycleNum - lastRise != JIFFY_INTERVAL + 1)
				begin
					errorCount++;
					$display("** Error jiffy period: expected %0d, actual %0d",
						JIFFY_INTERVAL + 1, cycleNum - lastRise);
				end
				jiffyRises++;
				lastRise = cycleNum;
				highCycles = 0;
			end
			if (jiffyIrq)
				highCycles++;
			if (!jiffyIrq && irqSeen && highCycles != IRQ_LENGTH)
			begin
				errorCount++;
				$display("** Error jiffy width: expected %0d, actual %0d",
					IRQ_LENGTH, highCycles);
			end
			irqSeen = jiffyIrq;
		end
	end

endmodule

// ==== tbIoController.sv ====
`timescale 1ns/1ps

module tbIoController;
	import ioPkg::*;

	localparam int WAIT_LIMIT = 2000;       // Cycles allowed per handshake wait
	localparam int JIFFY_LIMIT = 1200000;   // Two timer periods plus margin

	logic clk;
	logic reset;
	logic reqValid;
	busReqT req;
	logic creditReturn;
	logic respValid;
	busRespT resp;
	logic [7:0] led;
	logic jiffyIrq;

	// Expectation channel into the checker
	logic expValid;
	busRespT expResp;
	logic [2:0] expTest;
	logic endCheck;
	int checkErrors;
	int pending;                // Reads still waiting for a response
	int jiffyRises;

	int credits;
	int tbErrors;
	integer seed;

	// Register model
	logic [15:0] mFacA;
	logic [15:0] mFacB;
	logic [1:0] mGfx;
	logic [7:0] mX;
	logic [7:0] mY;
	logic [7:0] mLfsr;
	logic [7:0] mLed;

	ioController UUT (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.creditReturn(creditReturn),
		.respValid(respValid),
		.resp(resp),
		.led(led),
		.jiffyIrq(jiffyIrq)
	);

	ioChecker respCheck (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.creditReturn(creditReturn),
		.respValid(respValid),
		.resp(resp),
		.jiffyIrq(jiffyIrq),
		.expValid(expValid),
		.expResp(expResp),
		.expTest(expTest),
		.endCheck(endCheck),
		.errorCount(checkErrors),
		.pending(pending),
		.jiffyRises(jiffyRises)
	);

	always #2 clk = ~clk;   // 4 ns period

	// One credit back per creditReturn cycle
	always @(posedge clk)
	begin
		if (!reset && creditReturn)
			credits = credits + 1;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	// Taps 7, 5, 4, 3 shifted in at bit 0
	function automatic logic [7:0] lfsrNext(input logic [7:0] v);
		return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
	endfunction

	function automatic logic [7:0] expectedByte(input logic [15:0] addr);
		logic [31:0] prod;
		logic [15:0] scr;
		logic [7:0] pitch;
		logic [7:0] result;
		prod = 32'(mFacA) * 32'(mFacB);
		pitch = mGfx[1] ? GFX_PITCH : TEXT_PITCH;
		scr = 16'(32'(SCREEN_BASE) + 32'(mX) + 32'(mY) * 32'(pitch));  // Wraps at 64K
		case (addr)
			ADDR_PROD_0: result = prod[7:0];
			ADDR_PROD_1: result = prod[15:8];
			ADDR_PROD_2: result = prod[23:16];
			ADDR_PROD_3: result = prod[31:24];
			ADDR_RANDOM: result = mLfsr;
			ADDR_SCREEN_LO: result = scr[7:0];
			ADDR_SCREEN_HI: result = scr[15:8];
			16'hFFEA, 16'hFFFA: result = VEC_NMI[7:0];
			16'hFFEB, 16'hFFFB: result = VEC_NMI[15:8];
			16'hFFEE, 16'hFFFE: result = VEC_IRQ[7:0];
			16'hFFEF, 16'hFFFF: result = VEC_IRQ[15:8];
			16'hFFFC: result = VEC_RESET[7:0];
			16'hFFFD: result = VEC_RESET[15:8];
			default: result = 8'h00;   // No memory behind it
		endcase
		return result;
	endfunction

	function automatic void modelWrite(input logic [15:0] addr, input logic [7:0] data);
		case (addr)
			ADDR_LED: mLed = data;
			ADDR_FAC_A_LO: mFacA[7:0] = data;
			ADDR_FAC_A_HI: mFacA[15:8] = data;
			ADDR_FAC_B_LO: mFacB[7:0] = data;
			ADDR_FAC_B_HI: mFacB[15:8] = data;
			ADDR_GFX_MODE: mGfx = data[1:0];
			ADDR_SCREEN_X: mX = data;
			ADDR_SCREEN_Y: mY = data;
			default: ;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Host side of the bus
	////////////////////////////////////////////////////////////
	// Called 1 ns after a rising edge, returns at the same phase
	task automatic sendReq(input logic write, input logic [15:0] addr,
		input logic [7:0] data, input logic [2:0] testId);
		int guard;
		guard = 0;
		while (credits == 0 && guard < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			guard++;
		end
		if (credits == 0)
		begin
			tbErrors++;
			$display("Timeout waiting for a credit to send address %h", addr);
		end
		else
		begin
			credits--;
			reqValid = 1'b1;
			req.write = write;
			req.addr.raw = addr;
			req.data = data;
			if (write)
				modelWrite(addr, data);
			else
			begin
				expValid = 1'b1;
				expTest = testId;
				expResp.addr.raw = addr;
				expResp.data = expectedByte(addr);
				if (addr == ADDR_RANDOM)
					mLfsr = lfsrNext(mLfsr);   // Each read moves the sequence on
			end
			@(posedge clk);
			#1;
			reqValid = 1'b0;
			expValid = 1'b0;
		end
	endtask

	// All credits home and every read answered
	task automatic waitDrain();
		int guard;
		guard = 0;
		while ((credits != FIFO_DEPTH || pending != 0) && guard < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			guard++;
		end
		if (credits != FIFO_DEPTH || pending != 0)
		begin
			tbErrors++;
			$display("Timeout waiting for the DUT to drain its requests");
		end
	endtask

	// LED pins against the modeled byte
	task automatic checkLed();
		if (led !== mLed)
		begin
			tbErrors++;
			$display("** Error led: expected %h, actual %h", mLed, led);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial
	begin
		int a;
		int k;
		int guard;
		logic [1:0] pick;
		seed = 10;
		clk = 1'b0;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		expValid = 1'b0;
		expResp = '0;
		expTest = '0;
		endCheck = 1'b0;
		credits = FIFO_DEPTH;
		tbErrors = 0;
		mFacA = '0;
		mFacB = '0;
		mGfx = '0;
		mX = '0;
		mY = '0;
		mLfsr = LFSR_SEED;
		mLed = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Vector page, holes in it read as zero
		for (a = 16'hFFEA; a <= 16'hFFFF; a++)
			sendReq(1'b0, 16'(a), 8'h00, 3'd0);
		sendReq(1'b0, 16'h1234, 8'h00, 3'd0);
		sendReq(1'b0, 16'hFD05, 8'h00, 3'd0);   // Unused offset in the I/O page
		waitDrain();

		// Product reads right behind the factor writes hit the stall
		for (k = 0; k < 4; k++)
		begin
			sendReq(1'b1, ADDR_FAC_A_LO, (k == 0) ? 8'hFF : 8'($random(seed)), 3'd1);
			sendReq(1'b1, ADDR_FAC_A_HI, (k == 0) ? 8'hFF : 8'($random(seed)), 3'd1);
			sendReq(1'b1, ADDR_FAC_B_LO, (k == 0) ? 8'hFF : 8'($random(seed)), 3'd1);
			sendReq(1'b1, ADDR_FAC_B_HI, (k == 0) ? 8'hFF : 8'($random(seed)), 3'd1);
			if (k == 3)
			begin
				repeat (40) @(posedge clk);   // Let the multiply finish first
				#1;
			end
			for (a = 0; a < 4; a++)
				sendReq(1'b0, 16'(ADDR_PROD_0 + a), 8'h00, 3'd1);
		end
		waitDrain();

		// Screen address in text then graphics pitch
		for (k = 0; k < 4; k++)
		begin
			sendReq(1'b1, ADDR_GFX_MODE, (k < 2) ? 8'h00 : 8'h02, 3'd2);
			sendReq(1'b1, ADDR_SCREEN_X, 8'($random(seed)), 3'd2);
			sendReq(1'b1, ADDR_SCREEN_Y, 8'($random(seed)), 3'd2);
			sendReq(1'b0, ADDR_SCREEN_LO, 8'h00, 3'd2);
			sendReq(1'b0, ADDR_SCREEN_HI, 8'h00, 3'd2);
		end
		waitDrain();

		// Random byte sequence and LED
		for (k = 0; k < 6; k++)
			sendReq(1'b0, ADDR_RANDOM, 8'h00, 3'd3);
		sendReq(1'b1, ADDR_LED, 8'($random(seed)), 3'd3);
		waitDrain();
		checkLed();

		// Mixed burst, runs the host out of credits
		for (k = 0; k < 24; k++)
		begin
			pick = 2'($random(seed));
			case (pick)
				2'd0: sendReq(1'b1, ADDR_LED, 8'($random(seed)), 3'd4);
				2'd1: sendReq(1'b0, 16'(16'hFFFA + k % 6), 8'h00, 3'd4);
				2'd2: sendReq(1'b0, ADDR_RANDOM, 8'h00, 3'd4);
				default: sendReq(1'b0, 16'(ADDR_PROD_0 + k % 4), 8'h00, 3'd4);
			endcase
		end
		waitDrain();
		checkLed();

		// Checker times the pulses, wait for two of them
		guard = 0;
		while (jiffyRises < 2 && guard < JIFFY_LIMIT)
		begin
			@(posedge clk);
			guard++;
		end
		#1;
		if (jiffyRises < 2)
		begin
			tbErrors++;
			$display("Timeout waiting for two jiffy interrupts");
		end

		endCheck = 1'b1;
		@(posedge clk);
		#1;
		endCheck = 1'b0;
		@(posedge clk);
		#1;
		$display("Error count: %0d in checker, %0d in testbench", checkErrors, tbErrors);
		if (checkErrors == 0 && tbErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== files.f ====
ioPkg.sv
requestFifo.sv
busSequencer.sv
jiffyTimer.sv
mathUnit.sv
ioRegisters.sv
ioController.sv
ioChecker.sv
tbIoController.sv

// ==== Bender.yml ====
package:
  name: ioController

sources:
  - ioPkg.sv
  - requestFifo.sv
  - busSequencer.sv
  - jiffyTimer.sv
  - mathUnit.sv
  - ioRegisters.sv
  - ioController.sv
  - target: simulation
    files:
      - ioChecker.sv
      - tbIoController.sv
